//--- Bender.yml
package:
  name: lc3b_pipeline

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/lc3b_types.sv
      - src/fetch.sv
      - src/decode.sv
      - src/execute.sv
      - src/mem_stage.sv
      - src/mem_arbiter.sv
      - src/lc3b_pipeline.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_pmem.sv
      - tests/lc3b_pipeline_tb.sv

//--- src/decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_config.svh"

module decode import lc3b_types::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  fd_reg_t fd,
	input  de_reg_t de_in,
	input  em_reg_t em,
	input  mw_reg_t mw,
	input  logic    hold,
	input  logic    redirect,
	output de_reg_t de,
	output logic    stall
);

	lc3b_word regs [`LC3B_NUM_REGS];
	lc3b_nzp cc;
	lc3b_nzp wb_cc;
	lc3b_ctrl ctrl;
	lc3b_reg sr_a;
	lc3b_reg sr_b;
	logic use_a;
	logic use_b;
	logic raw_hit;
	logic cc_hit;
	logic dep_stall;

	function automatic logic reg_hit(
		input logic valid,
		input logic ld_reg,
		input lc3b_reg dest,
		input lc3b_reg a,
		input lc3b_reg b,
		input logic ua,
		input logic ub
	);
		return valid && ld_reg && ((ua && dest == a) || (ub && dest == b));
	endfunction

	always_comb begin
		ctrl = '0;
		ctrl.opcode = op_nop;
		ctrl.alu_op = alu_pass;
		use_a = 1'b0;
		use_b = 1'b0;
		sr_a = fd.ir[8:6];
		sr_b = fd.ir[2:0];
		case (fd.ir[15:12])
			op_add, op_and: begin
				ctrl.opcode = lc3b_opcode'(fd.ir[15:12]);
				ctrl.alu_op = (fd.ir[15:12] == op_add) ? alu_add : alu_and;
				ctrl.imm_sel = fd.ir[5];
				ctrl.ld_reg = 1'b1;
				ctrl.ld_cc = 1'b1;
				use_a = 1'b1;
				use_b = !fd.ir[5];
			end
			op_not: begin
				ctrl.opcode = op_not;
				ctrl.alu_op = alu_not;
				ctrl.ld_reg = 1'b1;
				ctrl.ld_cc = 1'b1;
				use_a = 1'b1;
			end
			op_br: ctrl.opcode = op_br;
			op_lea: begin
				// LC-3b LEA leaves the condition codes alone
				ctrl.opcode = op_lea;
				ctrl.ld_reg = 1'b1;
			end
			op_ldr: begin
				ctrl.opcode = op_ldr;
				ctrl.mem_read = 1'b1;
				ctrl.ld_reg = 1'b1;
				ctrl.ld_cc = 1'b1;
				use_a = 1'b1;
			end
			op_str: begin
				ctrl.opcode = op_str;
				ctrl.mem_write = 1'b1;
				sr_b = fd.ir[11:9];
				use_a = 1'b1;
				use_b = 1'b1;
			end
			default: ;
		endcase
	end

	// interlock against everything not yet written back
	assign raw_hit = reg_hit(de_in.valid, de_in.ctrl.ld_reg, de_in.dest, sr_a, sr_b, use_a, use_b)
		|| reg_hit(em.valid, em.ctrl.ld_reg, em.dest, sr_a, sr_b, use_a, use_b)
		|| reg_hit(mw.valid, mw.ctrl.ld_reg, mw.dest, sr_a, sr_b, use_a, use_b);
	assign cc_hit = (ctrl.opcode == op_br) && ((de_in.valid && de_in.ctrl.ld_cc)
		|| (em.valid && em.ctrl.ld_cc) || (mw.valid && mw.ctrl.ld_cc));
	assign dep_stall = fd.valid && (raw_hit || cc_hit);
	assign stall = dep_stall || hold;

	always_comb begin
		if (mw.result[15])
			wb_cc = 3'b100;
		else if (mw.result == '0)
			wb_cc = 3'b010;
		else
			wb_cc = 3'b001;
	end

	always_ff @(posedge clk) begin
		if (mw.valid && mw.ctrl.ld_reg)
			regs[mw.dest] <= mw.result;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			cc <= 3'b010;
		else if (mw.valid && mw.ctrl.ld_cc)
			cc <= wb_cc;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de <= '0;
		end else if (redirect || (dep_stall && !hold)) begin
			de.valid <= 1'b0;
			de.ctrl.opcode <= op_nop;
		end else if (!hold) begin
			de.npc <= fd.npc;
			de.ir <= fd.ir;
			de.ctrl <= ctrl;
			de.src_a <= regs[sr_a];
			de.src_b <= regs[sr_b];
			de.dest <= fd.ir[11:9];
			de.cc <= cc;
			de.valid <= fd.valid;
		end
	end

endmodule : decode

`default_nettype wire

//--- src/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute import lc3b_types::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  de_reg_t  de,
	input  logic     hold,
	output em_reg_t  em,
	output logic     redirect,
	output lc3b_word target
);

	lc3b_word imm5;
	lc3b_word pc_off;
	lc3b_word base_off;
	lc3b_word alu_b;
	lc3b_word alu_out;
	logic taken;

	assign imm5 = {{11{de.ir[4]}}, de.ir[4:0]};

	// offsets are in words, shifted to bytes
	assign pc_off = de.npc + {{6{de.ir[8]}}, de.ir[8:0], 1'b0};
	assign base_off = de.src_a + {{9{de.ir[5]}}, de.ir[5:0], 1'b0};

	always_comb begin
		if (de.ctrl.opcode == op_lea)
			alu_b = pc_off;
		else if (de.ctrl.imm_sel)
			alu_b = imm5;
		else
			alu_b = de.src_b;
	end

	always_comb begin
		case (de.ctrl.alu_op)
			alu_add: alu_out = de.src_a + alu_b;
			alu_and: alu_out = de.src_a & alu_b;
			alu_not: alu_out = ~de.src_a;
			default: alu_out = alu_b;
		endcase
	end

	assign taken = |(de.ir[11:9] & de.cc);

	// fires once, in the cycle the branch moves on
	assign redirect = de.valid && (de.ctrl.opcode == op_br) && taken && !hold;
	assign target = pc_off;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			em <= '0;
		end else if (!hold) begin
			em.ctrl <= de.ctrl;
			em.addr <= base_off;
			em.result <= alu_out;
			em.dest <= de.dest;
			em.store_data <= de.src_b;
			em.valid <= de.valid;
		end
	end

endmodule : execute

`default_nettype wire

//--- src/fetch.sv
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_config.svh"

module fetch import lc3b_types::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     stall,
	input  logic     redirect,
	input  lc3b_word target,
	input  logic     resp,
	input  lc3b_word rdata,
	output mem_req_t req,
	output fd_reg_t  fd,
	output logic     fd_stall
);

	lc3b_word pc;
	lc3b_word pc_next;
	logic busy;
	logic stale;
	logic can_issue;

	assign pc_next = pc + 16'd2;

	// room for a new word once decode takes the current one
	assign can_issue = !fd.valid || !stall;

	always_comb begin
		req = '0;
		req.read = busy || (can_issue && !redirect);
		req.addr = pc;
	end

	assign fd_stall = req.read && !resp;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `LC3B_RESET_PC;
			busy <= 1'b0;
			stale <= 1'b0;
		end else begin
			busy <= req.read && !resp;
			if (resp)
				stale <= 1'b0;
			else if (redirect && busy)
				stale <= 1'b1;
			if (redirect)
				pc <= target;
			else if (resp && !stale)
				pc <= pc_next;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fd <= '0;
		end else if (redirect) begin
			fd.valid <= 1'b0;
		end else if (resp && !stale) begin
			fd.npc <= pc_next;
			fd.ir <= rdata;
			fd.valid <= 1'b1;
		end else if (!stall) begin
			// word consumed, nothing new yet
			fd.valid <= 1'b0;
		end
	end

endmodule : fetch

`default_nettype wire

//--- src/lc3b_config.svh
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// byte address of the first instruction fetch
`define LC3B_RESET_PC 16'h0000

// register file depth
`define LC3B_NUM_REGS 8

`endif

//--- src/lc3b_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module lc3b_pipeline import lc3b_types::*; (
	input  logic     clk,
	input  logic     arst_n,

	// physical memory port
	input  logic     pmem_resp,
	input  lc3b_word pmem_rdata,
	output logic     pmem_read,
	output logic     pmem_write,
	output lc3b_word pmem_address,
	output lc3b_word pmem_wdata
);

	// stage registers
	fd_reg_t fd;
	de_reg_t de;
	em_reg_t em;
	mw_reg_t mw;

	// arbiter side
	mem_req_t ireq;
	mem_req_t dreq;
	logic iresp;
	logic dresp;

	// branch and stall chain
	logic redirect;
	lc3b_word target;
	logic de_stall;
	logic mem_hold;

	// fd_stall left open, fd.valid already tells decode
	fetch fetch_int (
		.clk,
		.arst_n,
		.stall(de_stall),
		.redirect,
		.target,
		.resp(iresp),
		.rdata(pmem_rdata),
		.req(ireq),
		.fd,
		.fd_stall()
	);

	decode decode_int (
		.clk,
		.arst_n,
		.fd,
		.de_in(de),
		.em,
		.mw,
		.hold(mem_hold),
		.redirect,
		.de,
		.stall(de_stall)
	);

	execute execute_int (
		.clk,
		.arst_n,
		.de,
		.hold(mem_hold),
		.em,
		.redirect,
		.target
	);

	mem_stage mem_int (
		.clk,
		.arst_n,
		.em,
		.resp(dresp),
		.rdata(pmem_rdata),
		.req(dreq),
		.mw,
		.hold(mem_hold)
	);

	mem_arbiter arbiter (
		.clk,
		.arst_n,
		.ireq,
		.dreq,
		.pmem_resp,
		.iresp,
		.dresp,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata
	);

endmodule : lc3b_pipeline

`default_nettype wire

//--- src/lc3b_types.sv
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	// LC-3b encodings, op_nop marks bubbles
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_nop = 4'b1000,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_alu_op;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_alu_op alu_op;
		logic imm_sel;
		logic ld_reg;
		logic ld_cc;
		logic mem_read;
		logic mem_write;
	} lc3b_ctrl;

	typedef struct packed {
		lc3b_word npc;
		lc3b_word ir;
		logic valid;
	} fd_reg_t;

	typedef struct packed {
		lc3b_word npc;
		lc3b_word ir;
		lc3b_ctrl ctrl;
		lc3b_word src_a;
		lc3b_word src_b;
		lc3b_reg dest;
		lc3b_nzp cc;
		logic valid;
	} de_reg_t;

	typedef struct packed {
		lc3b_ctrl ctrl;
		lc3b_word addr;
		lc3b_word result;
		lc3b_reg dest;
		lc3b_word store_data;
		logic valid;
	} em_reg_t;

	typedef struct packed {
		lc3b_ctrl ctrl;
		lc3b_word result;
		lc3b_reg dest;
		logic valid;
	} mw_reg_t;

	typedef struct packed {
		logic read;
		logic write;
		lc3b_word addr;
		lc3b_word wdata;
	} mem_req_t;

endpackage : lc3b_types

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter import lc3b_types::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  mem_req_t ireq,
	input  mem_req_t dreq,
	input  logic     pmem_resp,
	output logic     iresp,
	output logic     dresp,
	output logic     pmem_read,
	output logic     pmem_write,
	output lc3b_word pmem_address,
	output lc3b_word pmem_wdata
);

	typedef enum logic [1:0] {
		st_idle,
		st_ifetch,
		st_data
	} state_t;

	state_t state;
	state_t state_next;
	lc3b_word addr_q;
	lc3b_word wdata_q;
	logic write_q;
	logic dpend;

	assign dpend = dreq.read || dreq.write;

	// data side first
	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (dpend)
					state_next = st_data;
				else if (ireq.read)
					state_next = st_ifetch;
			end
			default: begin
				if (pmem_resp)
					state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= st_idle;
		else
			state <= state_next;
	end

	// request captured at grant, port stays steady until resp
	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			addr_q <= dpend ? dreq.addr : ireq.addr;
			wdata_q <= dreq.wdata;
			write_q <= dpend && dreq.write;
		end
	end

	assign pmem_read = (state == st_ifetch) || (state == st_data && !write_q);
	assign pmem_write = (state == st_data) && write_q;
	assign pmem_address = addr_q;
	assign pmem_wdata = wdata_q;

	assign iresp = (state == st_ifetch) && pmem_resp;
	assign dresp = (state == st_data) && pmem_resp;

endmodule : mem_arbiter

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage import lc3b_types::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  em_reg_t  em,
	input  logic     resp,
	input  lc3b_word rdata,
	output mem_req_t req,
	output mw_reg_t  mw,
	output logic     hold
);

	logic access;

	assign access = em.valid && (em.ctrl.mem_read || em.ctrl.mem_write);

	always_comb begin
		req.read = em.valid && em.ctrl.mem_read;
		req.write = em.valid && em.ctrl.mem_write;
		req.addr = em.addr;
		req.wdata = em.store_data;
	end

	// whole pipe waits on the data port
	assign hold = access && !resp;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mw <= '0;
		end else if (hold) begin
			mw.valid <= 1'b0;
			mw.ctrl.opcode <= op_nop;
		end else begin
			mw.ctrl <= em.ctrl;
			mw.result <= em.ctrl.mem_read ? rdata : em.result;
			mw.dest <= em.dest;
			mw.valid <= em.valid;
		end
	end

endmodule : mem_stage

`default_nettype wire

//--- tests/lc3b_pipeline_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_config.svh"

module lc3b_pipeline_tb import lc3b_types::*; ();

	// LC-3b encodings
	localparam logic [3:0] opc_br = 4'b0000;
	localparam logic [3:0] opc_add = 4'b0001;
	localparam logic [3:0] opc_and = 4'b0101;
	localparam logic [3:0] opc_ldr = 4'b0110;
	localparam logic [3:0] opc_str = 4'b0111;
	localparam logic [3:0] opc_not = 4'b1001;
	localparam logic [3:0] opc_lea = 4'b1110;

	logic clk;
	logic arst_n;
	logic pmem_resp;
	lc3b_word pmem_rdata;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_word pmem_wdata;
	int write_count;
	int unsigned mem_delay = 0;
	logic random_delays = 1'b0;
	logic [31:0] rng = 32'h3e4f_7585;

	lc3b_word prog [$];
	lc3b_word exp_addr [$];
	lc3b_word exp_data [$];

	lc3b_pipeline UUT (
		.clk,
		.arst_n,
		.pmem_resp,
		.pmem_rdata,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata
	);

	tb_pmem mem_model (
		.clk,
		.arst_n,
		.read(pmem_read),
		.write(pmem_write),
		.address(pmem_address),
		.wdata(pmem_wdata),
		.delay(mem_delay),
		.resp(pmem_resp),
		.rdata(pmem_rdata),
		.writes(write_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// memory latches this only while idle
	always @(negedge clk)
		mem_delay <= random_delays ? next_random() % 5 : 0;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic give_up(input string what);
		$display("%s at %0t", what, $time);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	function automatic lc3b_word sext(input lc3b_word v, input int bits);
		lc3b_word t;
		t = v << (16 - bits);
		return $signed(t) >>> (16 - bits);
	endfunction

	function automatic lc3b_nzp nzp_of(input lc3b_word v);
		if (v[15])
			return 3'b100;
		else if (v == '0)
			return 3'b010;
		return 3'b001;
	endfunction

	function automatic lc3b_word enc_reg(input logic [3:0] op, input int dr, input int sa,
		input int sb);
		return {op, 3'(dr), 3'(sa), 3'b000, 3'(sb)};
	endfunction

	function automatic lc3b_word enc_imm(input logic [3:0] op, input int dr, input int sa,
		input int imm);
		return {op, 3'(dr), 3'(sa), 1'b1, 5'(imm)};
	endfunction

	// LDR, STR, and NOT with an offset of -1
	function automatic lc3b_word enc_off6(input logic [3:0] op, input int r, input int base,
		input int off);
		return {op, 3'(r), 3'(base), 6'(off)};
	endfunction

	// BR and LEA
	function automatic lc3b_word enc_off9(input logic [3:0] op, input int r, input int off);
		return {op, 3'(r), 9'(off)};
	endfunction

	// sequential LC-3b model, builds the expected store log
	task automatic run_model(output lc3b_word halt_pc);
		lc3b_word m [lc3b_word];
		lc3b_word r [8];
		lc3b_word pc;
		lc3b_word ir;
		lc3b_word a;
		lc3b_word b;
		lc3b_word ea;
		lc3b_word res;
		lc3b_nzp cc;
		logic done;
		int i;
		exp_addr.delete();
		exp_data.delete();
		for (i = 0; i < prog.size(); i++)
			m[`LC3B_RESET_PC + 16'(2 * i)] = prog[i];
		for (i = 0; i < 8; i++)
			r[i] = '0;
		pc = `LC3B_RESET_PC;
		cc = 3'b010;
		done = 1'b0;
		halt_pc = pc;
		for (i = 0; i < 1000 && !done; i++) begin
			ir = m.exists(pc) ? m[pc] : '0;
			pc = pc + 16'd2;
			a = r[ir[8:6]];
			b = ir[5] ? sext(ir, 5) : r[ir[2:0]];
			ea = a + (sext(ir, 6) << 1);
			case (ir[15:12])
				opc_add: res = a + b;
				opc_and: res = a & b;
				opc_not: res = ~a;
				opc_ldr: res = m.exists(ea) ? m[ea] : '0;
				default: res = '0;
			endcase
			case (ir[15:12])
				opc_add, opc_and, opc_not, opc_ldr: begin
					r[ir[11:9]] = res;
					cc = nzp_of(res);
				end
				opc_lea: r[ir[11:9]] = pc + (sext(ir, 9) << 1);
				opc_str: begin
					m[ea] = r[ir[11:9]];
					exp_addr.push_back(ea);
					exp_data.push_back(r[ir[11:9]]);
				end
				opc_br: begin
					if (|(ir[11:9] & cc)) begin
						halt_pc = pc - 16'd2;
						pc = pc + (sext(ir, 9) << 1);
						done = (pc == halt_pc);
					end
				end
				default: ;
			endcase
		end
		if (!done)
			give_up("reference model never reached its halt loop");
	endtask

	task automatic run_program(input string name);
		lc3b_word halt_pc;
		int cycles;
		int halts;
		int i;
		run_model(halt_pc);
		@(negedge clk);
		arst_n = 1'b0;
		for (i = 0; i < prog.size(); i++)
			mem_model.mem[(`LC3B_RESET_PC >> 1) + i] = prog[i];
		repeat (2) begin
			@(posedge clk);
			check({name, " pmem_read in reset"}, pmem_read, 0);
			check({name, " pmem_write in reset"}, pmem_write, 0);
		end
		@(negedge clk);
		arst_n = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > 20)
				give_up({name, ": no memory request after reset"});
		end while (!(pmem_read || pmem_write));
		check({name, " first pmem_read"}, pmem_read, 1);
		check({name, " first pmem_write"}, pmem_write, 0);
		check({name, " first pmem_address"}, pmem_address, `LC3B_RESET_PC);
		// halt loop fetched three times, so the last BR has run
		halts = 0;
		cycles = 0;
		while (write_count < exp_addr.size() || halts < 3) begin
			@(posedge clk);
			if (pmem_resp && pmem_read && pmem_address == halt_pc)
				halts++;
			cycles++;
			if (cycles > 20000)
				give_up({name, ": program did not reach its halt loop"});
		end
		check({name, " write count"}, write_count, exp_addr.size());
		for (i = 0; i < exp_addr.size(); i++) begin
			check({name, " store address"}, mem_model.log_addr[i], exp_addr[i]);
			check({name, " store data"}, mem_model.log_data[i], exp_data[i]);
		end
	endtask

	task automatic test_alu();
		prog = '{
			enc_off9(opc_lea, 7, 127),
			enc_imm(opc_and, 0, 0, 0),
			enc_imm(opc_add, 0, 0, 13),
			enc_off6(opc_str, 0, 7, 0),
			enc_imm(opc_and, 1, 1, 0),
			enc_imm(opc_add, 1, 1, -6),
			enc_off6(opc_str, 1, 7, 1),
			enc_reg(opc_add, 2, 0, 1),
			enc_off6(opc_str, 2, 7, 2),
			enc_reg(opc_and, 3, 1, 0),
			enc_off6(opc_str, 3, 7, 3),
			enc_imm(opc_and, 4, 1, -4),
			enc_off6(opc_str, 4, 7, 4),
			enc_off6(opc_not, 5, 1, -1),
			enc_off6(opc_str, 5, 7, 5),
			enc_imm(opc_add, 6, 5, -16),
			enc_off6(opc_str, 6, 7, -1),
			enc_off9(opc_br, 7, -1)
		};
		run_program("alu");
	endtask

	task automatic test_interlock();
		prog = '{
			enc_off9(opc_lea, 7, 127),
			enc_imm(opc_and, 1, 1, 0),
			enc_imm(opc_add, 1, 1, 1),
			enc_reg(opc_add, 1, 1, 1),
			enc_reg(opc_add, 1, 1, 1),
			enc_imm(opc_add, 2, 1, 3),
			enc_off6(opc_str, 2, 7, 0),
			enc_off9(opc_lea, 3, 8),
			enc_off6(opc_ldr, 4, 3, 0),
			enc_reg(opc_add, 5, 4, 2),
			enc_off6(opc_str, 5, 7, 1),
			enc_off6(opc_str, 4, 7, 2),
			enc_off6(opc_ldr, 6, 7, 1),
			enc_off6(opc_not, 6, 6, -1),
			enc_off6(opc_str, 6, 7, 3),
			enc_off9(opc_br, 7, -1),
			16'h1234
		};
		run_program("interlock");
	endtask

	task automatic test_branch();
		lc3b_word set_cc [3];
		logic [2:0] mask [10];
		int kind [10];
		int k;
		// z, p, n
		set_cc[0] = enc_imm(opc_and, 0, 0, 0);
		set_cc[1] = enc_imm(opc_add, 0, 2, 0);
		set_cc[2] = enc_imm(opc_add, 0, 3, 0);
		mask = '{3'b100, 3'b010, 3'b001, 3'b110, 3'b100, 3'b011, 3'b101, 3'b101, 3'b111, 3'b000};
		kind = '{0, 0, 1, 1, 2, 2, 0, 1, 2, 1};
		prog = '{
			enc_off9(opc_lea, 7, 127),
			enc_imm(opc_and, 2, 2, 0),
			enc_imm(opc_add, 2, 2, 5),
			enc_imm(opc_and, 3, 3, 0),
			enc_imm(opc_add, 3, 3, -3)
		};
		// taken branch skips its store
		for (k = 0; k < 10; k++) begin
			prog.push_back(set_cc[kind[k]]);
			prog.push_back(enc_off9(opc_br, mask[k], 1));
			prog.push_back(enc_off6(opc_str, 0, 7, k));
		end
		prog.push_back(enc_off9(opc_br, 7, -1));
		run_program("branch");
	endtask

	initial begin
		arst_n = 1'b0;
		test_alu();
		test_interlock();
		test_branch();
		random_delays = 1'b1;
		test_alu();
		test_interlock();
		test_branch();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule : lc3b_pipeline_tb

`default_nettype wire

//--- tests/tb_pmem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pmem import lc3b_types::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        read,
	input  logic        write,
	input  lc3b_word    address,
	input  lc3b_word    wdata,
	input  int unsigned delay,
	output logic        resp,
	output lc3b_word    rdata,
	output int          writes
);

	lc3b_word mem [32768];
	lc3b_word log_addr [$];
	lc3b_word log_data [$];
	int unsigned delay_q;
	int unsigned waited;
	logic busy;
	int i;

	initial begin
		for (i = 0; i < 32768; i++)
			mem[i] = 16'(i * 40093) ^ 16'h7e01;
		resp = 1'b0;
		rdata = '0;
		writes = 0;
		busy = 1'b0;
		waited = 0;
		delay_q = 0;
	end

	// delay only picked up between accesses
	always @(posedge clk)
		if (!busy)
			delay_q <= delay;

	always @(negedge clk) begin
		if (!arst_n) begin
			resp <= 1'b0;
			busy <= 1'b0;
			waited <= 0;
			writes <= 0;
			log_addr.delete();
			log_data.delete();
		end else if (resp) begin
			resp <= 1'b0;
			busy <= 1'b0;
			waited <= 0;
		end else if (read || write) begin
			busy <= 1'b1;
			if (waited < delay_q) begin
				waited <= waited + 1;
			end else begin
				resp <= 1'b1;
				if (write) begin
					mem[address[15:1]] <= wdata;
					log_addr.push_back(address);
					log_data.push_back(wdata);
					writes <= writes + 1;
				end else begin
					rdata <= mem[address[15:1]];
				end
			end
		end
	end

endmodule : tb_pmem

`default_nettype wire

//--- vlog.f
+incdir+src
src/lc3b_types.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/mem_stage.sv
src/mem_arbiter.sv
src/lc3b_pipeline.sv
tests/tb_pmem.sv
tests/lc3b_pipeline_tb.sv
